// ==== build.f ====
common/fetch_pkg.sv
common/mem_pkg.sv
fetch/fetch_control.sv
fetch/next_pc.sv
icache/icache.sv
hdl/fetch_top.sv
dv/fetch_tb.sv

// ==== common/fetch_pkg.sv ====
`default_nettype none

// ********************************************************************
// Fetch side definitions
// ********************************************************************

package fetch_pkg;

  // Width of a program counter and of one instruction word.
  localparam int XLEN = 32;

  // Address of the first instruction fetched after reset.
  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // Major opcode (bits 6:2) shared by all conditional branches.
  localparam logic [4:0] OPCODE_BRANCH = 5'b11000;

  // A pc correction from a later stage of the pipeline.
  // When valid is set, fetch continues at target and drops
  // whatever it currently holds.
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  // Payload handed downstream together with out_valid.
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } fetch_out_t;

endpackage

`default_nettype wire

// ==== common/mem_pkg.sv ====
`default_nettype none

// ********************************************************************
// Instruction cache geometry and memory read bus
// ********************************************************************

package mem_pkg;

  localparam int LINE_WORDS = 4;
  localparam int NUM_LINES  = 16;

  // Byte offset within a line, line index, and the remaining tag bits.
  localparam int OFFSET_BITS = $clog2(LINE_WORDS * 4);
  localparam int INDEX_BITS  = $clog2(NUM_LINES);
  localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

  // Line read request. The address is always line aligned.
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } mem_req_t;

  // One response beat. Beats come back in address order and the
  // final one of a line carries last.
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  import fetch_pkg::*;
  import mem_pkg::*;

  localparam int NUM_XFERS    = 400;
  localparam int WORST_CYCLES = 120;

  // Two always-taken backward branches close small loops.
  localparam logic [31:0] LOOP_A_BR  = 32'h8000_0040;
  localparam logic [31:0] LOOP_A_TOP = 32'h8000_0020;
  localparam logic [31:0] LOOP_B_BR  = 32'h8000_0300;
  localparam logic [31:0] LOOP_B_TOP = 32'h8000_0280;

  logic       clock;
  logic       reset;
  redirect_t  redirect;
  logic       out_ready;
  logic       out_valid;
  fetch_out_t out;
  mem_req_t   mem_req;
  logic       mem_req_ready;
  mem_rsp_t   mem_rsp;

  logic [31:0] lfsr = 32'h0eb8_11e7;
  int          xfer_count = 0;
  int          error_count = 0;

  fetch_top DUT (
    .clock         (clock),
    .reset         (reset),
    .redirect      (redirect),
    .out_ready     (out_ready),
    .out_valid     (out_valid),
    .out           (out),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp       (mem_rsp)
  );

  // ********************************************************************
  // Program, reference model and random bits
  // ********************************************************************

  function automatic logic [31:0] encode_branch(logic [31:0] from, logic [31:0] to);
    logic [31:0] off;
    off = to - from;
    // BEQ x0, x0 with the B-type immediate scattered over the word.
    return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] prog_word(logic [31:0] addr);
    if (addr == LOOP_A_BR) begin
      return encode_branch(LOOP_A_BR, LOOP_A_TOP);
    end else if (addr == LOOP_B_BR) begin
      return encode_branch(LOOP_B_BR, LOOP_B_TOP);
    end
    return {addr[26:2], 7'b0010011};
  endfunction

  function automatic logic [31:0] ref_next_pc(logic [31:0] pc, logic [31:0] inst);
    logic [31:0] offset;
    offset = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    if (inst[6:0] == 7'b1100011 && offset[31]) begin
      return pc + offset;
    end
    return pc + 32'd4;
  endfunction

  function automatic logic [31:0] line_of(logic [31:0] addr);
    return {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    end
    return v;
  endfunction

  // ********************************************************************
  // Compare tasks
  // ********************************************************************

  task automatic report_failure();
    error_count++;
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_fetch(string name, fetch_out_t got, fetch_out_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got pc=%h inst=%h, expected pc=%h inst=%h",
               $time, name, got.pc, got.inst, exp.pc, exp.inst);
      report_failure();
    end
  endtask

  task automatic check_req(mem_req_t got, mem_req_t exp);
    if (got !== exp) begin
      $display("error at %0t: mem_req got valid=%b addr=%h, expected valid=%b addr=%h",
               $time, got.valid, got.addr, exp.valid, exp.addr);
      report_failure();
    end
  endtask

  // ********************************************************************
  // Clock, reset and stimulus
  // ********************************************************************

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    reset         = 1'b1;
    redirect      = '0;
    out_ready     = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp       = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
  end

  // Memory model and downstream stage.
  initial begin : stimulus
    logic [31:0] fill_addr;
    logic [31:0] r;
    int          beats_left;
    fill_addr  = '0;
    beats_left = 0;
    forever begin
      @(posedge clock);
      if (beats_left == 0 && mem_req.valid && mem_req_ready) begin
        fill_addr  = mem_req.addr;
        beats_left = LINE_WORDS;
      end
      mem_rsp <= '0;
      r = take_bits(1);
      if (beats_left > 0 && r[0]) begin
        mem_rsp <= '{valid: 1'b1,
                     data: prog_word(fill_addr + 32'(4 * (LINE_WORDS - beats_left))),
                     last: (beats_left == 1)};
        beats_left--;
      end
      r = take_bits(1);
      mem_req_ready <= r[0];
      r = take_bits(2);
      out_ready <= (r[1:0] != 2'b00);
      redirect <= '0;
      if (!reset && take_bits(5) == 32'd0) begin
        redirect <= '{valid: 1'b1, target: RESET_PC + (take_bits(10) << 2)};
      end
    end
  end

  // ********************************************************************
  // Checker, sampled at the falling edge where everything is settled
  // ********************************************************************

  initial begin : monitor
    logic [31:0]         exp_pc;
    logic [31:0]         next_line;
    logic [31:0]         fill_line;
    logic [31:0]         recent[$];
    fetch_out_t          held;
    fetch_out_t          exp_out;
    logic                held_valid;
    logic                req_seen;
    mem_req_t            exp_req;
    logic                res_valid[NUM_LINES];
    logic [TAG_BITS-1:0] res_tag[NUM_LINES];
    exp_pc     = RESET_PC;
    fill_line  = '0;
    held       = '0;
    held_valid = 1'b0;
    req_seen   = 1'b0;
    for (int i = 0; i < NUM_LINES; i++) begin
      res_valid[i] = 1'b0;
      res_tag[i]   = '0;
    end
    forever begin
      @(negedge clock);
      if (!reset) begin
        if (held_valid) begin
          check_fetch("out", out, held);
        end
        held_valid = out_valid && !out_ready;
        held       = out;
        if (redirect.valid && out_valid) begin
          $display("output was valid in the same cycle as a redirect at %0t", $time);
          report_failure();
        end
        if (out_valid && out_ready) begin
          exp_out = '{pc: exp_pc, inst: prog_word(exp_pc)};
          check_fetch("out", out, exp_out);
          exp_pc = ref_next_pc(exp_pc, prog_word(exp_pc));
          recent.delete();
          xfer_count++;
        end
        if (redirect.valid) begin
          recent.push_back(exp_pc);
          exp_pc = redirect.target;
        end

        // A new request must name the line that fetch needs next.
        if (mem_req.valid && !req_seen) begin
          exp_req   = '{valid: 1'b1, addr: line_of(exp_pc)};
          next_line = line_of(ref_next_pc(exp_pc, prog_word(exp_pc)));
          if (mem_req.addr == next_line) begin
            exp_req.addr = next_line;
          end
          foreach (recent[i]) begin
            if (mem_req.addr == line_of(recent[i])) begin
              exp_req.addr = line_of(recent[i]);
            end
            // A look-ahead started just before the redirect is also allowed.
            next_line = line_of(ref_next_pc(recent[i], prog_word(recent[i])));
            if (mem_req.addr == next_line) begin
              exp_req.addr = next_line;
            end
          end
          check_req(mem_req, exp_req);
          fill_line = mem_req.addr;
          if (res_valid[fill_line[OFFSET_BITS +: INDEX_BITS]] &&
              res_tag[fill_line[OFFSET_BITS +: INDEX_BITS]] == fill_line[31 -: TAG_BITS]) begin
            $display("cache requested line %h that is already resident", fill_line);
            report_failure();
          end
          res_valid[fill_line[OFFSET_BITS +: INDEX_BITS]] = 1'b0;
        end
        req_seen = mem_req.valid;
        if (mem_rsp.valid && mem_rsp.last) begin
          res_valid[fill_line[OFFSET_BITS +: INDEX_BITS]] = 1'b1;
          res_tag[fill_line[OFFSET_BITS +: INDEX_BITS]]   = fill_line[31 -: TAG_BITS];
        end
      end
    end
  end

  initial begin
    wait (xfer_count >= NUM_XFERS);
    @(negedge clock);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized for a slow miss on every transfer.
  initial begin
    repeat (NUM_XFERS * WORST_CYCLES) @(posedge clock);
    $display("fetch stalled after %0d of %0d transfers", xfer_count, NUM_XFERS);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== fetch/fetch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  out_ready,
  output logic                  out_valid,
  output fetch_pkg::fetch_out_t out,
  input  logic [31:0]           predicted_pc,
  output logic [31:0]           lookup_addr,
  input  logic                  hit,
  input  logic [31:0]           hit_inst,
  output fetch_pkg::redirect_t  pend_redirect
);

  import fetch_pkg::*;

  typedef enum logic {
    ST_WAIT = 1'b0,
    ST_HOLD = 1'b1
  } state_t;

  state_t          state;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] inst;
  redirect_t       pend;
  logic            advance;

  // In HOLD the stage moves on after a transfer, or when it must
  // throw the held instruction away because of a redirect.
  assign advance = (state == ST_HOLD) &&
                   ((out_valid && out_ready) || redirect.valid || pend.valid);

  // While holding, look ahead at the next pc so that a hit can be
  // loaded in the same edge as the transfer.
  assign lookup_addr = (state == ST_HOLD) ? predicted_pc : pc;

  assign out_valid     = (state == ST_HOLD) && !redirect.valid && !pend.valid;
  assign out           = '{pc: pc, inst: inst};
  assign pend_redirect = pend;

  // ********************************************************************
  // State, pc and deferred redirect
  // ********************************************************************

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_WAIT;
      pc    <= RESET_PC;
      pend  <= '0;
    end else begin
      case (state)
        ST_HOLD: begin
          if (advance) begin
            pc         <= predicted_pc;
            pend.valid <= 1'b0;
            if (!hit) begin
              state <= ST_WAIT;
            end
          end
        end
        default: begin
          // A redirect during a miss is kept until the refill ends.
          if (redirect.valid) begin
            pend <= redirect;
          end
          if (hit) begin
            state <= ST_HOLD;
          end
        end
      endcase
    end
  end

  // Held instruction.
  always_ff @(posedge clock) begin
    if ((advance && hit) || (state == ST_WAIT && hit)) begin
      inst <= hit_inst;
    end
  end

  // ********************************************************************
  // Checks
  // ********************************************************************

  a_out_stable: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready && !redirect.valid |=> $stable(out));

  a_wait_redirect_quiet: assert property (@(posedge clock) disable iff (reset)
    (state == ST_WAIT) && redirect.valid |=> !out_valid);

endmodule

`default_nettype wire

// ==== fetch/next_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module next_pc (
  input  logic [31:0]          pc,
  input  logic [31:0]          inst,
  input  fetch_pkg::redirect_t redirect,
  input  fetch_pkg::redirect_t pend_redirect,
  output logic [31:0]          predicted_pc
);

  import fetch_pkg::*;

  logic [XLEN-1:0] imm_b;
  logic            back_branch;
  logic [XLEN-1:0] pc_step;

  // B-type immediate, bit 0 is always zero.
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  // Backward conditional branches are predicted taken, since they
  // usually close a loop.
  assign back_branch = (inst[6:2] == OPCODE_BRANCH) && inst[31];
  assign pc_step     = back_branch ? imm_b : 32'd4;

  always_comb begin
    if (redirect.valid) begin
      predicted_pc = redirect.target;
    end else if (pend_redirect.valid) begin
      predicted_pc = pend_redirect.target;
    end else begin
      predicted_pc = pc + pc_step;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  out_ready,
  output logic                  out_valid,
  output fetch_pkg::fetch_out_t out,
  output mem_pkg::mem_req_t     mem_req,
  input  logic                  mem_req_ready,
  input  mem_pkg::mem_rsp_t     mem_rsp
);

  import fetch_pkg::*;

  redirect_t       pend_redirect;
  logic [XLEN-1:0] predicted_pc;
  logic [XLEN-1:0] lookup_addr;
  logic            hit;
  logic [XLEN-1:0] hit_inst;

  fetch_control control (
    .clock         (clock),
    .reset         (reset),
    .redirect      (redirect),
    .out_ready     (out_ready),
    .out_valid     (out_valid),
    .out           (out),
    .predicted_pc  (predicted_pc),
    .lookup_addr   (lookup_addr),
    .hit           (hit),
    .hit_inst      (hit_inst),
    .pend_redirect (pend_redirect)
  );

  next_pc predictor (
    .pc            (out.pc),
    .inst          (out.inst),
    .redirect      (redirect),
    .pend_redirect (pend_redirect),
    .predicted_pc  (predicted_pc)
  );

  icache cache (
    .clock         (clock),
    .reset         (reset),
    .addr          (lookup_addr),
    .hit           (hit),
    .inst          (hit_inst),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp       (mem_rsp)
  );

endmodule

`default_nettype wire

// ==== icache/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic              clock,
  input  logic              reset,
  input  logic [31:0]       addr,
  output logic              hit,
  output logic [31:0]       inst,
  output mem_pkg::mem_req_t mem_req,
  input  logic              mem_req_ready,
  input  mem_pkg::mem_rsp_t mem_rsp
);

  import mem_pkg::*;

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQ,
    RF_FILL
  } refill_t;

  // ********************************************************************
  // Storage and lookup
  // ********************************************************************

  logic [TAG_BITS-1:0] tag_mem   [NUM_LINES];
  logic [31:0]         data_mem  [NUM_LINES][LINE_WORDS];
  logic [NUM_LINES-1:0] valid_mem;

  logic [TAG_BITS-1:0]    addr_tag;
  logic [INDEX_BITS-1:0]  addr_index;
  logic [OFFSET_BITS-3:0] addr_word;

  assign addr_tag   = addr[31 -: TAG_BITS];
  assign addr_index = addr[OFFSET_BITS +: INDEX_BITS];
  assign addr_word  = addr[OFFSET_BITS-1:2];

  assign hit  = valid_mem[addr_index] && (tag_mem[addr_index] == addr_tag);
  assign inst = data_mem[addr_index][addr_word];

  // ********************************************************************
  // Refill engine
  // ********************************************************************

  refill_t                          rf_state;
  logic                             req_valid;
  logic [TAG_BITS+INDEX_BITS-1:0]   fill_line;
  logic [INDEX_BITS-1:0]            fill_index;
  logic [OFFSET_BITS-3:0]           beat_cnt;
  logic                             start_fill;

  assign start_fill = (rf_state == RF_IDLE) && !hit;
  assign fill_index = fill_line[INDEX_BITS-1:0];

  // The address comes from the latched line, so it holds still until accepted.
  assign mem_req = '{valid: req_valid, addr: {fill_line, {OFFSET_BITS{1'b0}}}};

  always_ff @(posedge clock) begin
    if (reset) begin
      rf_state  <= RF_IDLE;
      req_valid <= 1'b0;
      valid_mem <= '0;
      beat_cnt  <= '0;
    end else begin
      case (rf_state)
        RF_IDLE: begin
          if (start_fill) begin
            // The victim line goes invalid before any of its words change.
            valid_mem[addr_index] <= 1'b0;
            req_valid             <= 1'b1;
            rf_state              <= RF_REQ;
          end
        end
        RF_REQ: begin
          if (mem_req_ready) begin
            req_valid <= 1'b0;
            beat_cnt  <= '0;
            rf_state  <= RF_FILL;
          end
        end
        default: begin
          if (mem_rsp.valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (mem_rsp.last) begin
              valid_mem[fill_index] <= 1'b1;
              rf_state              <= RF_IDLE;
            end
          end
        end
      endcase
    end
  end

  // Line address, tags and data words.
  always_ff @(posedge clock) begin
    if (start_fill) begin
      fill_line           <= addr[31:OFFSET_BITS];
      tag_mem[addr_index] <= addr_tag;
    end
    if (rf_state == RF_FILL && mem_rsp.valid) begin
      data_mem[fill_index][beat_cnt] <= mem_rsp.data;
    end
  end

  // ********************************************************************
  // Checks
  // ********************************************************************

  a_req_steady: assert property (@(posedge clock) disable iff (reset)
    mem_req.valid && !mem_req_ready |=> $stable(mem_req));

  a_no_beat_idle: assert property (@(posedge clock) disable iff (reset)
    mem_rsp.valid |-> rf_state != RF_IDLE);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f build.f \
  --top-module fetch_tb \
  -o Vfetch_tb

./obj_dir/Vfetch_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
